// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_playfield
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+.
pf_mode_pkg.sv
pf_fetch_pkg.sv
pf_ifs.sv
pf_config_regs.sv
pf_line_timing.sv
pf_fetch_fsm.sv
pf_pixel_shifter.sv
playfield_top.sv
pf_checker.sv
pf_assertions.sv
tb_playfield.sv

// ==== pf_assertions.sv ====
module pf_assertions import pf_fetch_pkg::*; (
    input logic      clk,
    input logic      reset_i,
    input logic      vram_sel_o,       // read select of the fetch FSM
    input logic      fetch_active,     // fetch window level
    input logic      words_ready,      // words handed to the shifter
    input logic      buf_full,         // shifter buffer level
    input fetch_st_t state             // fetch FSM state
);

    // a read only starts from FETCH_ADDR with the window open
    sel_in_window: assert property (@(posedge clk) disable iff (reset_i)
        $rose(vram_sel_o) |-> $past(fetch_active))
        else $error("vram read started outside the fetch window");

    no_ready_when_full: assert property (@(posedge clk) disable iff (reset_i)
        words_ready |-> !buf_full)
        else $error("words_ready while pixel buffer full");

    legal_state: assert property (@(posedge clk) disable iff (reset_i)
        state inside {FETCH_IDLE, FETCH_ADDR, FETCH_WAIT, FETCH_READ_0, FETCH_READ_1})
        else $error("fetch FSM in illegal state");

endmodule

// ==== pf_checker.sv ====
`include "pf_consts.svh"

module pf_checker import pf_mode_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`PF_HCOUNT_W-1:0] h_count_i,
    input  logic                    v_visible_i,
    input  logic                    line_last_i,
    input  logic                    frame_last_i,
    input  logic                    reg_wr_i,
    input  logic [1:0]              reg_addr_i,
    input  logic [`PF_WORD_W-1:0]   reg_data_i,
    input  logic                    vram_sel_i,     // dut vram_sel_o
    input  pixel_idx_t              color_i,        // dut color_o
    input  logic                    active_i,       // dut active_o
    input  logic [63:0]             test_name_i,    // 8 ascii chars
    output int                      err_count_o,
    output int                      pix_count_o     // pixels compared while active
);

    localparam int SCAN_BEGIN = `PF_OFFSCREEN_WIDTH - `PF_SCANOUT_LEAD;
    localparam int SCAN_END   = `PF_TOTAL_WIDTH - `PF_SCANOUT_LEAD;
    localparam int MEM_BEGIN  = `PF_OFFSCREEN_WIDTH - `PF_MEM_LEAD;
    localparam int MEM_END    = `PF_TOTAL_WIDTH - `PF_MEM_TAIL;

    logic [15:0] start_sh, len_sh;      // shadow of the register block
    logic        bpp8_sh, blank_sh;
    pixel_idx_t  cb_sh, border_sh;
    logic [15:0] base;                  // first word of current line
    logic        fetch_on, scan_on;     // expected windows
    logic        exp_act;
    pixel_idx_t  exp_color;
    int          h;

    // pixel k of a line whose words start at line_base, vram word a = a ^ a5c3
    function automatic pixel_idx_t model_pixel(input logic [15:0] line_base, input int k,
                                               input logic bpp8);
        logic [15:0] w;
        logic [15:0] sh;
        if (bpp8) begin
            w = (line_base + 16'(k / 2)) ^ 16'hA5C3;
            model_pixel = (k % 2 == 1) ? w[7:0] : w[15:8];  // high byte first
        end else begin
            w  = (line_base + 16'(k / 4)) ^ 16'hA5C3;
            sh = w >> (4 * (3 - (k % 4)));                  // high nibble first
            model_pixel = {4'h0, sh[3:0]};
        end
    endfunction

    always @(posedge clk) begin
        if (reset_i) begin
            start_sh    = '0;
            len_sh      = '0;
            bpp8_sh     = 1'b0;
            blank_sh    = 1'b1;
            cb_sh       = '0;
            border_sh   = '0;
            base        = '0;
            fetch_on    = 1'b0;
            scan_on     = 1'b0;
            err_count_o = 0;
            pix_count_o = 0;
        end else begin
            h       = int'(h_count_i);
            exp_act = scan_on;
            if (exp_act) begin
                exp_color = model_pixel(base, h - SCAN_BEGIN - 1, bpp8_sh) ^ cb_sh;
                pix_count_o++;
            end else begin
                exp_color = border_sh ^ cb_sh;              // border outside scanout
            end
            if (active_i !== exp_act) begin
                $display("** Error %s: active_o at h=%0d expected %b actual %b",
                         test_name_i, h, exp_act, active_i);
                err_count_o++;
            end
            if (color_i !== exp_color) begin
                $display("** Error %s: color_o at h=%0d expected %h actual %h",
                         test_name_i, h, exp_color, color_i);
                err_count_o++;
            end
            if (vram_sel_i && (!v_visible_i || blank_sh || h <= MEM_BEGIN + 1 ||
                               h >= MEM_END + 4)) begin
                $display("vram_sel_o was high outside the fetch window at h=%0d in test %s",
                         h, test_name_i);
                err_count_o++;
            end
            // model state for next cycle
            if (h == SCAN_END) scan_on = 1'b0;
            if (fetch_on && h == SCAN_BEGIN) scan_on = 1'b1;
            if (blank_sh || (fetch_on && h == MEM_END)) begin
                fetch_on = 1'b0;
            end else if (!fetch_on && v_visible_i && h == MEM_BEGIN) begin
                fetch_on = 1'b1;
            end
            if (blank_sh || frame_last_i) base = start_sh;  // frame restart
            else if (line_last_i) base = base + len_sh;
            if (reg_wr_i) begin
                case (reg_addr_i)
                    `PF_REG_START:    start_sh = reg_data_i;
                    `PF_REG_LINE_LEN: len_sh   = reg_data_i;
                    `PF_REG_MODE: begin
                        blank_sh = reg_data_i[`PF_MODE_BLANK_BIT];
                        bpp8_sh  = reg_data_i[`PF_MODE_BPP_BIT];
                        cb_sh    = reg_data_i[7:0];
                    end
                    default:          border_sh = reg_data_i[7:0];
                endcase
            end
        end
    end

endmodule

// ==== pf_config_regs.sv ====
`include "pf_consts.svh"

module pf_config_regs import pf_mode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  reg_wr_i,     // write strobe
    input  logic [1:0]            reg_addr_i,   // register select
    input  logic [`PF_WORD_W-1:0] reg_data_i,   // write data
    pf_cfg_if.source              cfg
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg.start_addr <= '0;
            cfg.line_len   <= '0;
            cfg.bpp        <= BPP_4;
            cfg.colorbase  <= '0;
            cfg.border     <= '0;
            cfg.blank      <= 1'b1;                     // come up blanked
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                `PF_REG_START:    cfg.start_addr <= reg_data_i;     // used at next frame
                `PF_REG_LINE_LEN: cfg.line_len   <= reg_data_i;
                `PF_REG_MODE: begin
                    cfg.blank     <= reg_data_i[`PF_MODE_BLANK_BIT];
                    cfg.bpp       <= reg_data_i[`PF_MODE_BPP_BIT] ? BPP_8 : BPP_4;
                    cfg.colorbase <= reg_data_i[7:0];
                end
                `PF_REG_BORDER:   cfg.border     <= reg_data_i[7:0];
                default: ;
            endcase
        end
    end

endmodule

// ==== pf_consts.svh ====
`ifndef PF_CONSTS_SVH
`define PF_CONSTS_SVH

// line geometry in pixel clocks
`define PF_TOTAL_WIDTH      160         // pixels per line incl. offscreen
`define PF_OFFSCREEN_WIDTH  72          // first visible pixel
`define PF_MEM_LEAD         64          // fetch opens this far before visible area
`define PF_MEM_TAIL         8           // fetch closes this far before line end
`define PF_SCANOUT_LEAD     2           // scanout starts this many counts early

// bus widths
`define PF_HCOUNT_W         11          // horizontal count
`define PF_ADDR_W           16          // vram word address
`define PF_WORD_W           16          // vram data word and register data

// register map, 2-bit address
`define PF_REG_START        2'd0        // display start address
`define PF_REG_LINE_LEN     2'd1        // words per line
`define PF_REG_MODE         2'd2        // blank, bpp, colorbase
`define PF_REG_BORDER       2'd3        // border color
`define PF_MODE_BLANK_BIT   15          // mode reg: 1 = playfield blanked
`define PF_MODE_BPP_BIT     8           // mode reg: 1 = 8 bpp, 0 = 4 bpp

`endif

// ==== pf_fetch_fsm.sv ====
`include "pf_consts.svh"

module pf_fetch_fsm import pf_mode_pkg::*, pf_fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [`PF_WORD_W-1:0] vram_data_i,  // read data, one clock after select
    output logic                  vram_sel_o,   // read select
    output logic [`PF_ADDR_W-1:0] vram_addr_o,  // read word address
    pf_cfg_if.sink                cfg,
    pf_line_if.sink               line,
    pf_words_if.source            words
);

    fetch_st_t             state, state_next;
    logic [`PF_ADDR_W-1:0] fetch_ptr, fetch_ptr_next;   // next word to read
    logic [`PF_ADDR_W-1:0] addr_next;
    logic                  sel_next;
    logic                  initial_buf, initial_buf_next;   // nothing captured yet this line
    logic                  ready_next;

    always_comb begin
        state_next       = state;
        fetch_ptr_next   = fetch_ptr;
        addr_next        = vram_addr_o;
        sel_next         = 1'b0;
        ready_next       = 1'b0;
        initial_buf_next = initial_buf;
        case (state)
            FETCH_IDLE: begin
                if (line.fetch_active) state_next = FETCH_ADDR;
            end
            FETCH_ADDR: begin
                if (!line.fetch_active) begin
                    state_next = FETCH_IDLE;            // window closed
                end else if (!words.buf_full) begin     // hold here while buffer full
                    sel_next       = 1'b1;
                    addr_next      = fetch_ptr;
                    fetch_ptr_next = fetch_ptr + 1'b1;
                    state_next     = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (cfg.bpp == BPP_8) begin             // second word for 8 bpp
                    sel_next       = 1'b1;
                    addr_next      = fetch_ptr;
                    fetch_ptr_next = fetch_ptr + 1'b1;
                end
                ready_next       = !initial_buf;        // previous words still held in word0/1
                initial_buf_next = 1'b0;
                state_next       = FETCH_READ_0;
            end
            FETCH_READ_0: state_next = (cfg.bpp == BPP_8) ? FETCH_READ_1 : FETCH_ADDR;
            FETCH_READ_1: state_next = FETCH_ADDR;
            default:      state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state             <= FETCH_IDLE;
            vram_sel_o        <= 1'b0;
            words.words_ready <= 1'b0;
            initial_buf       <= 1'b0;
        end else begin
            state             <= state_next;
            vram_sel_o        <= sel_next;
            words.words_ready <= ready_next;
            initial_buf       <= line.line_fetch_start ? 1'b1 : initial_buf_next;
        end
    end

    always_ff @(posedge clk) begin
        vram_addr_o <= addr_next;
        fetch_ptr   <= line.line_fetch_start ? line.line_addr : fetch_ptr_next;   // line start
        if (state == FETCH_READ_0) words.word0 <= vram_data_i;
        if (state == FETCH_READ_1) words.word1 <= vram_data_i;
    end

endmodule

// ==== pf_fetch_pkg.sv ====
package pf_fetch_pkg;

    // vram fetch sequencer states
    typedef enum logic [2:0] {
        FETCH_IDLE   = 3'd0,            // waiting for fetch window
        FETCH_ADDR   = 3'd1,            // first read out, if buffer has room
        FETCH_WAIT   = 3'd2,            // second read out at 8 bpp
        FETCH_READ_0 = 3'd3,            // word0 on vram data
        FETCH_READ_1 = 3'd4             // word1 on vram data
    } fetch_st_t;

endpackage

// ==== pf_ifs.sv ====
`include "pf_consts.svh"

// playfield configuration from the register block
interface pf_cfg_if import pf_mode_pkg::*; ();
    logic [`PF_ADDR_W-1:0] start_addr;  // first word of frame
    logic [`PF_ADDR_W-1:0] line_len;    // words added per line
    bpp_t                  bpp;         // display depth
    pixel_idx_t            colorbase;   // XORed into every pixel
    pixel_idx_t            border;      // color outside scanout
    logic                  blank;       // playfield off

    modport source (output start_addr, line_len, bpp, colorbase, border, blank);
    modport sink   (input  start_addr, line_len, bpp, colorbase, border, blank);
endinterface

// per-line windows and address
interface pf_line_if;
    logic                  fetch_active;        // vram fetch window open
    logic                  line_fetch_start;    // first cycle of window
    logic                  scanout_start;       // load first group
    logic                  scanout_end;         // stop shifting
    logic [`PF_ADDR_W-1:0] line_addr;           // first word of this line

    modport source (output fetch_active, line_fetch_start, scanout_start, scanout_end,
                    line_addr);
    modport sink   (input  fetch_active, line_fetch_start, scanout_start, scanout_end,
                    line_addr);
endinterface

// fetched words towards the pixel buffer
interface pf_words_if;
    logic [`PF_WORD_W-1:0] word0;       // first word of a fetch
    logic [`PF_WORD_W-1:0] word1;       // second word, 8 bpp only
    logic                  words_ready; // words valid this cycle
    logic                  buf_full;    // pixel buffer holds 8 pixels

    modport source (output word0, word1, words_ready, input  buf_full);
    modport sink   (input  word0, word1, words_ready, output buf_full);
endinterface

// ==== pf_line_timing.sv ====
`include "pf_consts.svh"

module pf_line_timing (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`PF_HCOUNT_W-1:0] h_count_i,      // pixel position in line
    input  logic                    v_visible_i,    // line is in visible area
    input  logic                    line_last_i,    // last pixel of line
    input  logic                    frame_last_i,   // last pixel of frame
    pf_cfg_if.sink                  cfg,
    pf_line_if.source               line
);

    localparam logic [`PF_HCOUNT_W-1:0] H_MEM_BEGIN =
        `PF_HCOUNT_W'(`PF_OFFSCREEN_WIDTH - `PF_MEM_LEAD);
    localparam logic [`PF_HCOUNT_W-1:0] H_MEM_END =
        `PF_HCOUNT_W'(`PF_TOTAL_WIDTH - `PF_MEM_TAIL);
    localparam logic [`PF_HCOUNT_W-1:0] H_SCAN_BEGIN =
        `PF_HCOUNT_W'(`PF_OFFSCREEN_WIDTH - `PF_SCANOUT_LEAD);
    localparam logic [`PF_HCOUNT_W-1:0] H_SCAN_END =
        `PF_HCOUNT_W'(`PF_TOTAL_WIDTH - `PF_SCANOUT_LEAD);

    logic                  fetch_active;        // fetch window level
    logic                  fetch_start;         // registered window open pulse
    logic                  fetch_rise;          // window opens next clock
    logic                  fetch_fall;          // window closes next clock
    logic [`PF_ADDR_W-1:0] line_addr;           // start word of current line

    assign fetch_rise = !fetch_active && v_visible_i && !cfg.blank && (h_count_i == H_MEM_BEGIN);
    assign fetch_fall = fetch_active && (h_count_i == H_MEM_END);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_active <= 1'b0;
            fetch_start  <= 1'b0;
            line_addr    <= '0;
        end else begin
            fetch_start <= fetch_rise;                  // lines up with first active cycle
            if (cfg.blank || fetch_fall) begin
                fetch_active <= 1'b0;
            end else if (fetch_rise) begin
                fetch_active <= 1'b1;
            end
            if (cfg.blank || frame_last_i) begin
                line_addr <= cfg.start_addr;            // new frame, pick up start reg
            end else if (line_last_i) begin
                line_addr <= line_addr + cfg.line_len;  // next line of bitmap
            end
        end
    end

    assign line.fetch_active     = fetch_active;
    assign line.line_fetch_start = fetch_start;
    assign line.scanout_start    = fetch_active && (h_count_i == H_SCAN_BEGIN); // only on fetched lines
    assign line.scanout_end      = (h_count_i == H_SCAN_END);
    assign line.line_addr        = line_addr;

endmodule

// ==== pf_mode_pkg.sv ====
package pf_mode_pkg;

    // bits per pixel of display data
    typedef enum logic [1:0] {
        BPP_4 = 2'b00,                  // nibble per pixel
        BPP_8 = 2'b01                   // byte per pixel
    } bpp_t;

    typedef logic [7:0] pixel_idx_t;    // color index

    typedef pixel_idx_t [7:0] pixel_group_t;   // element 7 is shown first

endpackage

// ==== pf_pixel_shifter.sv ====
`include "pf_consts.svh"

module pf_pixel_shifter import pf_mode_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    output pixel_idx_t color_o,         // color index out
    output logic       active_o,        // display enable
    pf_cfg_if.sink     cfg,
    pf_line_if.sink    line,
    pf_words_if.sink   words
);

    pixel_group_t buf_pix;              // next 8 pixels
    pixel_group_t shift_pix;            // pixels going out, element 7 first
    logic         buf_full;
    logic         half_sel;             // 0 = fill first four pixels
    logic         scanout;
    logic [2:0]   pix_x;                // pixel within group
    logic         load;                 // shift register takes buffer

    // four pixels from one fetch, one word at 4 bpp or two at 8 bpp
    function automatic logic [31:0] expand_half(input logic [`PF_WORD_W-1:0] w0,
                                                input logic [`PF_WORD_W-1:0] w1,
                                                input bpp_t bpp);
        if (bpp == BPP_8) begin
            expand_half = {w0, w1};     // byte per pixel already
        end else begin
            expand_half = {4'h0, w0[15:12], 4'h0, w0[11:8], 4'h0, w0[7:4], 4'h0, w0[3:0]};
        end
    endfunction

    assign load = line.scanout_start || (scanout && pix_x == 3'd7);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full <= 1'b0;
            half_sel <= 1'b0;
            scanout  <= 1'b0;
            pix_x    <= '0;
        end else begin
            if (scanout) pix_x <= pix_x + 1'b1;
            if (load) buf_full <= 1'b0;                 // buffer moved out, room again
            if (line.scanout_start) begin
                scanout <= 1'b1;
                pix_x   <= '0;
            end
            if (line.scanout_end) scanout <= 1'b0;
            if (words.words_ready) begin
                half_sel <= ~half_sel;
                if (half_sel) buf_full <= 1'b1;         // second half done
            end
            if (line.line_fetch_start) begin
                buf_full <= 1'b0;
                half_sel <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_pix <= buf_pix;
        end else if (scanout) begin
            shift_pix <= {shift_pix[6:0], cfg.border};  // border shifts in behind
        end
        if (words.words_ready) begin
            if (half_sel) buf_pix[3:0] <= expand_half(words.word0, words.word1, cfg.bpp);
            else          buf_pix[7:4] <= expand_half(words.word0, words.word1, cfg.bpp);
        end
    end

    assign words.buf_full = buf_full;
    assign active_o       = scanout;
    assign color_o        = (scanout ? shift_pix[7] : cfg.border) ^ cfg.colorbase;

endmodule

// ==== playfield_top.sv ====
`include "pf_consts.svh"

module playfield_top import pf_mode_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`PF_HCOUNT_W-1:0] h_count_i,      // horizontal position
    input  logic                    v_visible_i,    // visible line
    input  logic                    line_last_i,    // last pixel of line
    input  logic                    frame_last_i,   // last pixel of frame
    input  logic                    reg_wr_i,       // register write strobe
    input  logic [1:0]              reg_addr_i,
    input  logic [`PF_WORD_W-1:0]   reg_data_i,
    output logic                    vram_sel_o,     // vram read select
    output logic [`PF_ADDR_W-1:0]   vram_addr_o,
    input  logic [`PF_WORD_W-1:0]   vram_data_i,    // one clock read latency
    output pixel_idx_t              color_o,
    output logic                    active_o        // display enable
);

    pf_cfg_if   cfg_if ();
    pf_line_if  line_if ();
    pf_words_if words_if ();

    pf_config_regs u_regs (
        .clk, .reset_i,
        .reg_wr_i, .reg_addr_i, .reg_data_i,
        .cfg        (cfg_if.source)
    );

    pf_line_timing u_timing (
        .clk, .reset_i,
        .h_count_i, .v_visible_i, .line_last_i, .frame_last_i,
        .cfg        (cfg_if.sink),
        .line       (line_if.source)
    );

    pf_fetch_fsm u_fetch (
        .clk, .reset_i,
        .vram_data_i, .vram_sel_o, .vram_addr_o,
        .cfg        (cfg_if.sink),
        .line       (line_if.sink),
        .words      (words_if.source)
    );

    pf_pixel_shifter u_shifter (
        .clk, .reset_i,
        .color_o, .active_o,
        .cfg        (cfg_if.sink),
        .line       (line_if.sink),
        .words      (words_if.sink)
    );

endmodule

// ==== tb_playfield.sv ====
`include "pf_consts.svh"

module tb_playfield import pf_mode_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int FRAMES    = 2;           // frames per test
    localparam int LINES     = 6;           // lines per frame with the last one invisible
    localparam longint WATCHDOG_T =
        longint'((NUM_TESTS + 1) * FRAMES * LINES * `PF_TOTAL_WIDTH) * 100 + 50000;

    logic                    clk, reset_i;
    logic [`PF_HCOUNT_W-1:0] h_count;
    logic                    v_visible, line_last, frame_last;
    logic                    reg_wr;
    logic [1:0]              reg_addr;
    logic [`PF_WORD_W-1:0]   reg_data;
    logic                    vram_sel;
    logic [`PF_ADDR_W-1:0]   vram_addr;
    logic [`PF_WORD_W-1:0]   vram_data;
    pixel_idx_t              color;
    logic                    active;
    logic [63:0]             test_name;
    int                      err_count, pix_count;
    int                      seed;
    logic [15:0]             cfg_word [4];  // start, line_len, mode, border for next test
    int                      errs_before, pix_before, passed, failed, kind;

    playfield_top dut (
        .clk, .reset_i,
        .h_count_i (h_count), .v_visible_i (v_visible),
        .line_last_i (line_last), .frame_last_i (frame_last),
        .reg_wr_i (reg_wr), .reg_addr_i (reg_addr), .reg_data_i (reg_data),
        .vram_sel_o (vram_sel), .vram_addr_o (vram_addr), .vram_data_i (vram_data),
        .color_o (color), .active_o (active)
    );

    pf_checker u_checker (
        .clk, .reset_i,
        .h_count_i (h_count), .v_visible_i (v_visible),
        .line_last_i (line_last), .frame_last_i (frame_last),
        .reg_wr_i (reg_wr), .reg_addr_i (reg_addr), .reg_data_i (reg_data),
        .vram_sel_i (vram_sel), .color_i (color), .active_i (active),
        .test_name_i (test_name), .err_count_o (err_count), .pix_count_o (pix_count)
    );

    bind pf_fetch_fsm pf_assertions u_fetch_asrt (
        .clk, .reset_i, .vram_sel_o,
        .fetch_active (line.fetch_active),
        .words_ready  (words.words_ready),
        .buf_full     (words.buf_full),
        .state
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // vram with one clock read latency and word a holding a ^ a5c3
    always @(posedge clk) begin
        if (vram_sel) vram_data <= vram_addr ^ 16'hA5C3;
    end

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    // random config for the next test where kind 2 sets blank
    task automatic choose_config(input int next_kind);
        logic [31:0] rnd;
        rnd         = $random(seed);
        cfg_word[0] = rnd[15:0];                            // start address
        cfg_word[1] = {11'd0, rnd[20:16]} + 16'd1;          // line length 1..32
        rnd         = $random(seed);
        cfg_word[2] = {next_kind == 2, 6'd0, next_kind == 0, rnd[7:0]};
        cfg_word[3] = {8'd0, rnd[15:8]};                    // border
    endtask

    // one frame with optional register writes early in the invisible line
    task automatic drive_frame(input logic write_cfg);
        int line;
        int h;
        for (line = 0; line < LINES; line++) begin
            for (h = 0; h < `PF_TOTAL_WIDTH; h++) begin
                @(negedge clk);
                h_count    = `PF_HCOUNT_W'(h);
                v_visible  = (line < LINES - 1);
                line_last  = (h == `PF_TOTAL_WIDTH - 1);
                frame_last = line_last && (line == LINES - 1);
                reg_wr     = write_cfg && (line == LINES - 1) && h >= 1 && h <= 4;
                reg_addr   = 2'(h - 1);
                reg_data   = reg_wr ? cfg_word[h - 1] : '0;
            end
        end
    endtask

    function automatic logic [63:0] name_of(input int k);
        case (k)
            0:       name_of = "bpp8_rnd";
            1:       name_of = "bpp4_rnd";
            default: name_of = "blank_on";
        endcase
    endfunction

    initial begin
        seed = 31611;
        reset_i = 1'b1;
        h_count = '0;
        v_visible = 1'b0;
        line_last = 1'b0;
        frame_last = 1'b0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        vram_data = '0;
        test_name = "reset   ";
        passed = 0;
        failed = 0;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        choose_config(0);
        drive_frame(1'b1);                                  // blanked lead-in frame
        if (err_count == 0) begin
            $display("reset lead-in frame ok");
        end else begin
            failed++;
            $display("reset lead-in frame failed with %0d errors", err_count);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            kind        = t % 3;
            test_name   = name_of(kind);
            errs_before = err_count;
            pix_before  = pix_count;
            if (t < NUM_TESTS - 1) choose_config((t + 1) % 3);
            for (int f = 0; f < FRAMES; f++) begin
                drive_frame(t < NUM_TESTS - 1 && f == FRAMES - 1);
            end
            if (err_count == errs_before) begin
                passed++;
                $display("test %0d %s ok, %0d pixels compared", t, test_name,
                         pix_count - pix_before);
            end else begin
                failed++;
                $display("test %0d %s failed with %0d errors", t, test_name,
                         err_count - errs_before);
            end
        end
        if (pix_count == 0) begin
            $display("no displayed pixel was ever compared");
            failed++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, passed,
                 failed, err_count);
        if (failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
